// File: verilog.f
common/pixbuf_pkg.sv
pixel_buffer/pixel_buffer_ram.sv
logic/cpu_bus_port.sv
video/pixel_fetch.sv
logic/pixbuf_top.sv
tests/pixbuf_props.sv
tests/pixbuf_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the pixel buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module pixbuf_tb -f verilog.f

# A simulation that stops early still prints what it got so far
out=$(./obj_dir/Vpixbuf_tb) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q -F '*** TEST PASSED ***'

// File: tests/pixbuf_tb.sv
`timescale 1ns/1ps

module pixbuf_tb;

	// Step kinds
	localparam int K_WRITE = 0;
	localparam int K_READ = 1;
	localparam int K_NOREAD = 2;
	localparam int K_VIDEO = 3;
	localparam int K_STREAM = 4;
	// Cycles allowed for a valid pulse
	localparam int WAIT_LIMIT = 8;
	localparam logic [31:0] CPU_BASE = {pixbuf_pkg::WINDOW_TAG, 13'h0000};

	logic Clock25Mhz;
	logic rst;
	logic [pixbuf_pkg::ADDR_W-1:0] addr;
	logic [pixbuf_pkg::DATA_W-1:0] wdata;
	logic as_l;
	logic rw;
	logic uds_l;
	logic lds_l;
	logic [pixbuf_pkg::DATA_W-1:0] cpu_rdata;
	logic cpu_rdata_valid;
	logic dma_read;
	logic [pixbuf_pkg::ADDR_W-1:0] dma_address;
	logic [pixbuf_pkg::RGB_W-1:0] dma_readdata;
	logic dma_readdatavalid;

	// Stimulus table with one entry per step
	int step_kind [$];
	string step_name [$];
	logic [31:0] step_addr [$];
	logic [15:0] step_data [$];
	// Strobes as {as_l, uds_l, lds_l}
	logic [2:0] step_strobe [$];
	logic [31:0] step_expected [$];

	// Mirror of the buffer bytes the table touches
	logic [7:0] ref_mem [0:8191];
	integer seed;
	int errors;
	int checks;

	pixbuf_top u_dut
	(
		.Clock25Mhz        (Clock25Mhz),
		.rst               (rst),
		.addr              (addr),
		.wdata             (wdata),
		.as_l              (as_l),
		.rw                (rw),
		.uds_l             (uds_l),
		.lds_l             (lds_l),
		.cpu_rdata         (cpu_rdata),
		.cpu_rdata_valid   (cpu_rdata_valid),
		.dma_read          (dma_read),
		.dma_address       (dma_address),
		.dma_readdata      (dma_readdata),
		.dma_readdatavalid (dma_readdatavalid)
	);

	// 25 MHz
	initial
	begin
		Clock25Mhz = 1'b0;
		forever
		begin
			#20 Clock25Mhz = ~Clock25Mhz;
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("ERROR %s: expected 0x%08h, got 0x%08h", name, expected, actual);
		end
	endtask

	task automatic push_step(input int kind, input string name, input logic [31:0] a,
		input logic [15:0] d, input logic [2:0] strobe, input logic [31:0] expected);
		step_kind.push_back(kind);
		step_name.push_back(name);
		step_addr.push_back(a);
		step_data.push_back(d);
		step_strobe.push_back(strobe);
		step_expected.push_back(expected);
	endtask

	task automatic add_write(input string name, input logic [31:0] a, input logic [15:0] d,
		input logic [2:0] strobe);
		// Low byte lands on a window hit whatever the strobes
		if (!strobe[2] && a[31:13] == pixbuf_pkg::WINDOW_TAG)
		begin
			ref_mem[a[12:0]] = d[7:0];
		end
		push_step(K_WRITE, name, a, d, strobe, 32'h0);
	endtask

	task automatic add_read(input string name, input logic [31:0] a, input logic [2:0] strobe);
		logic [7:0] b;
		logic [15:0] lanes;
		b = ref_mem[a[12:0]];
		// Byte on every lane whose strobe is low
		lanes = {strobe[1] ? 8'h00 : b, strobe[0] ? 8'h00 : b};
		if (!strobe[2] && a[31:13] == pixbuf_pkg::WINDOW_TAG)
		begin
			push_step(K_READ, name, a, 16'h0, strobe, 32'(lanes));
		end
		else
		begin
			push_step(K_NOREAD, name, a, 16'h0, strobe, 32'h0);
		end
	endtask

	// Rotated screen with byte row y/8 above column x
	function automatic logic [31:0] expected_pixel(input int x, input int y);
		logic [12:0] idx;
		logic [7:0] b;
		logic [2:0] sel;
		if (x >= 256 || y >= 256)
		begin
			return pixbuf_pkg::PIXEL_OFF;
		end
		idx = 13'((y / 8) * 256 + x);
		b = ref_mem[idx];
		sel = 3'(y % 8);
		return b[sel] ? pixbuf_pkg::PIXEL_ON : pixbuf_pkg::PIXEL_OFF;
	endfunction

	task automatic add_video(input string name, input int x, input int y, input int kind);
		// Word address with x from bit 2 and y from bit 12
		push_step(kind, name, (y << 12) | (x << 2), 16'h0, 3'b111, expected_pixel(x, y));
	endtask

	task automatic run_step(input int i);
		int cycles;
		logic seen;
		string pulse;
		@(posedge Clock25Mhz);
		if (step_kind[i] == K_VIDEO)
		begin
			dma_read <= 1'b1;
			dma_address <= step_addr[i];
		end
		else
		begin
			addr <= step_addr[i];
			wdata <= step_data[i];
			rw <= (step_kind[i] != K_WRITE);
			as_l <= step_strobe[i][2];
			uds_l <= step_strobe[i][1];
			lds_l <= step_strobe[i][0];
		end
		// DUT samples the request here
		@(posedge Clock25Mhz);
		as_l <= 1'b1;
		rw <= 1'b1;
		uds_l <= 1'b1;
		lds_l <= 1'b1;
		dma_read <= 1'b0;
		if (step_kind[i] != K_WRITE)
		begin
			cycles = 0;
			seen = 1'b0;
			pulse = (step_kind[i] == K_VIDEO) ? "dma_readdatavalid" : "cpu_rdata_valid";
			while (!seen && cycles < WAIT_LIMIT)
			begin
				@(negedge Clock25Mhz);
				cycles++;
				seen = (step_kind[i] == K_VIDEO) ? dma_readdatavalid : cpu_rdata_valid;
			end
			if (step_kind[i] == K_NOREAD)
			begin
				check_value({step_name[i], " valid"}, 32'h0, 32'(seen));
			end
			else if (!seen)
			begin
				errors++;
				$display("%s: no %s pulse within %0d cycles", step_name[i], pulse, WAIT_LIMIT);
			end
			else
			begin
				check_value({step_name[i], " latency"}, 32'd1, 32'(cycles));
				check_value(step_name[i], step_expected[i],
					(step_kind[i] == K_VIDEO) ? dma_readdata : 32'(cpu_rdata));
			end
		end
	endtask

	// Pixel reads on consecutive cycles
	task automatic run_stream(input int first, input int last);
		int k;
		@(posedge Clock25Mhz);
		dma_read <= 1'b1;
		dma_address <= step_addr[first];
		for (k = first; k < last; k++)
		begin
			// Request k sampled while the next one goes out
			@(posedge Clock25Mhz);
			if (k + 1 < last)
			begin
				dma_address <= step_addr[k + 1];
			end
			else
			begin
				dma_read <= 1'b0;
			end
			// Result k sits one cycle behind its request
			@(negedge Clock25Mhz);
			check_value({step_name[k], " valid"}, 32'h1, 32'(dma_readdatavalid));
			check_value(step_name[k], step_expected[k], dma_readdata);
		end
	endtask

	initial
	begin
		int i;
		int j;
		int k;
		rst = 1'b1;
		addr = '0;
		wdata = '0;
		as_l = 1'b1;
		rw = 1'b1;
		uds_l = 1'b1;
		lds_l = 1'b1;
		dma_read = 1'b0;
		dma_address = '0;
		errors = 0;
		checks = 0;
		seed = 32'h59a7;

		// Background fill with varying strobes
		add_write("fill a0", CPU_BASE + 32'h0123, 16'($random(seed)), 3'b011);
		add_write("fill col5 row3", CPU_BASE + 32'h0305, 16'($random(seed)), 3'b001);
		// Bit 7 stays set for the off-screen read at y 255
		add_write("fill col200 row31", CPU_BASE + 32'h1FC8,
			16'($random(seed)) | 16'h0080, 3'b010);
		add_write("fill col0 row0", CPU_BASE, 16'h00FF, 3'b000);
		// Write then read and lane steering
		add_write("write a0", CPU_BASE + 32'h0123, 16'h3CA5, 3'b000);
		add_read("read a0 both lanes", CPU_BASE + 32'h0123, 3'b000);
		add_read("read a0 upper lane", CPU_BASE + 32'h0123, 3'b001);
		add_read("read a0 lower lane", CPU_BASE + 32'h0123, 3'b010);
		// Stray cycles outside the window
		add_write("write other region", 32'h0200_0123, 16'h005A, 3'b000);
		add_write("write without as", CPU_BASE + 32'h0123, 16'h00C3, 3'b100);
		add_read("read a0 after stray writes", CPU_BASE + 32'h0123, 3'b000);
		add_read("read other region", 32'h0000_0123, 3'b000);
		add_read("read without as", CPU_BASE + 32'h0123, 3'b100);
		// New pattern at column 5 in byte row 3
		add_write("pattern col5 row3", CPU_BASE + 32'h0305, 16'h0096, 3'b001);
		for (k = 0; k < 8; k++)
		begin
			add_video($sformatf("pixel x5 y%0d", 24 + k), 5, 24 + k, K_VIDEO);
		end
		// Off screen reads whose mapped bits are set
		add_video("pixel x0 y0", 0, 0, K_VIDEO);
		add_video("pixel x256 y0", 256, 0, K_VIDEO);
		add_video("pixel x0 y256", 0, 256, K_VIDEO);
		add_video("pixel x456 y255", 456, 255, K_VIDEO);
		for (k = 0; k < 8; k++)
		begin
			add_video($sformatf("stream x200 y%0d", 248 + k), 200, 248 + k, K_STREAM);
		end
		for (k = 0; k < 4; k++)
		begin
			add_video($sformatf("stream x5 y%0d", 27 - k), 5, 27 - k, K_STREAM);
		end

		repeat (2) @(posedge Clock25Mhz);
		rst <= 1'b0;
		@(negedge Clock25Mhz);
		check_value("reset cpu_rdata_valid", 32'h0, 32'(cpu_rdata_valid));
		check_value("reset cpu_rdata", 32'h0, 32'(cpu_rdata));
		check_value("reset dma_readdatavalid", 32'h0, 32'(dma_readdatavalid));
		check_value("reset dma_readdata", 32'h0, dma_readdata);

		i = 0;
		while (i < step_kind.size())
		begin
			if (step_kind[i] == K_STREAM)
			begin
				// Gather the whole back-to-back group
				j = i;
				while (j < step_kind.size() && step_kind[j] == K_STREAM)
				begin
					j++;
				end
				run_stream(i, j);
				i = j;
			end
			else
			begin
				run_step(i);
				i++;
			end
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
		begin
			$display("*** TEST PASSED ***");
		end
		else
		begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: tests/pixbuf_props.sv
`timescale 1ns/1ps

module pixbuf_props
(
	input logic                            Clock25Mhz,
	input logic                            rst,
	input logic [pixbuf_pkg::ADDR_W-1:0]   addr,
	input logic                            as_l,
	input logic                            rw,
	input logic                            uds_l,
	input logic                            lds_l,
	input logic [pixbuf_pkg::DATA_W-1:0]   cpu_rdata,
	input logic                            cpu_rdata_valid,
	input logic                            dma_read,
	input logic [pixbuf_pkg::RGB_W-1:0]    dma_readdata,
	input logic                            dma_readdatavalid
);

	// CPU read inside the buffer window
	logic window_read;

	assign window_read = !as_l && rw &&
		(addr[pixbuf_pkg::ADDR_W-1:pixbuf_pkg::BUF_ADDR_W] == pixbuf_pkg::WINDOW_TAG);

	// Read valid exactly one cycle after the read
	assert property (@(posedge Clock25Mhz) disable iff (rst) window_read |=> cpu_rdata_valid)
		else $error("cpu_rdata_valid did not follow a window read");
	assert property (@(posedge Clock25Mhz) disable iff (rst) cpu_rdata_valid |-> $past(window_read))
		else $error("cpu_rdata_valid without a window read one cycle before");

	// Same for the pixel DMA side
	assert property (@(posedge Clock25Mhz) disable iff (rst) dma_read |=> dma_readdatavalid)
		else $error("dma_readdatavalid did not follow a pixel read");
	assert property (@(posedge Clock25Mhz) disable iff (rst) dma_readdatavalid |-> $past(dma_read))
		else $error("dma_readdatavalid without a pixel read one cycle before");

	// Lanes whose strobe was high stay zero
	assert property (@(posedge Clock25Mhz) disable iff (rst) $past(uds_l) |-> cpu_rdata[15:8] == 8'h00)
		else $error("upper lane driven without its strobe");
	assert property (@(posedge Clock25Mhz) disable iff (rst) $past(lds_l) |-> cpu_rdata[7:0] == 8'h00)
		else $error("lower lane driven without its strobe");

	// Quiet outputs right after a reset cycle
	assert property (@(posedge Clock25Mhz) $past(rst) |-> !cpu_rdata_valid && !dma_readdatavalid
		&& cpu_rdata == '0 && dma_readdata == '0)
		else $error("outputs not cleared by reset");

endmodule

bind pixbuf_top pixbuf_props u_props
(
	.Clock25Mhz        (Clock25Mhz),
	.rst               (rst),
	.addr              (addr),
	.as_l              (as_l),
	.rw                (rw),
	.uds_l             (uds_l),
	.lds_l             (lds_l),
	.cpu_rdata         (cpu_rdata),
	.cpu_rdata_valid   (cpu_rdata_valid),
	.dma_read          (dma_read),
	.dma_readdata      (dma_readdata),
	.dma_readdatavalid (dma_readdatavalid)
);

// File: logic/pixbuf_top.sv
`timescale 1ns/1ps

module pixbuf_top
(
	input  logic                                Clock25Mhz,
	input  logic                                rst,
	// 68000 bus
	input  logic [pixbuf_pkg::ADDR_W-1:0]       addr,
	input  logic [pixbuf_pkg::DATA_W-1:0]       wdata,
	input  logic                                as_l,
	input  logic                                rw,
	input  logic                                uds_l,
	input  logic                                lds_l,
	output logic [pixbuf_pkg::DATA_W-1:0]       cpu_rdata,
	output logic                                cpu_rdata_valid,
	// Pixel DMA
	input  logic                                dma_read,
	input  logic [pixbuf_pkg::ADDR_W-1:0]       dma_address,
	output logic [pixbuf_pkg::RGB_W-1:0]        dma_readdata,
	output logic                                dma_readdatavalid
);

	// Port A, CPU side
	logic [pixbuf_pkg::BUF_ADDR_W-1:0] a_addr;
	logic a_we;
	logic [pixbuf_pkg::BYTE_W-1:0] a_wdata;
	logic [pixbuf_pkg::BYTE_W-1:0] a_rdata;

	// Port B, video side
	logic [pixbuf_pkg::BUF_ADDR_W-1:0] b_addr;
	logic [pixbuf_pkg::BYTE_W-1:0] b_rdata;

	cpu_bus_port u_cpu_bus_port
	(
		.Clock25Mhz      (Clock25Mhz),
		.rst             (rst),
		.as_l            (as_l),
		.rw              (rw),
		.uds_l           (uds_l),
		.lds_l           (lds_l),
		.addr            (addr),
		.wdata           (wdata),
		.ram_rdata       (a_rdata),
		.ram_addr        (a_addr),
		.ram_we          (a_we),
		.ram_wdata       (a_wdata),
		.cpu_rdata       (cpu_rdata),
		.cpu_rdata_valid (cpu_rdata_valid)
	);

	// Shared 1 bpp frame store
	pixel_buffer_ram u_pixel_buffer_ram
	(
		.Clock25Mhz (Clock25Mhz),
		.a_addr     (a_addr),
		.a_we       (a_we),
		.a_wdata    (a_wdata),
		.a_rdata    (a_rdata),
		.b_addr     (b_addr),
		.b_rdata    (b_rdata)
	);

	pixel_fetch u_pixel_fetch
	(
		.Clock25Mhz        (Clock25Mhz),
		.rst               (rst),
		.dma_read          (dma_read),
		.dma_address       (dma_address),
		.ram_rdata         (b_rdata),
		.ram_addr          (b_addr),
		.dma_readdata      (dma_readdata),
		.dma_readdatavalid (dma_readdatavalid)
	);

endmodule

// File: video/pixel_fetch.sv
`timescale 1ns/1ps

module pixel_fetch
(
	input  logic                                Clock25Mhz,
	input  logic                                rst,
	input  logic                                dma_read,
	input  logic [pixbuf_pkg::ADDR_W-1:0]       dma_address,
	input  logic [pixbuf_pkg::BYTE_W-1:0]       ram_rdata,
	output logic [pixbuf_pkg::BUF_ADDR_W-1:0]   ram_addr,
	output logic [pixbuf_pkg::RGB_W-1:0]        dma_readdata,
	output logic                                dma_readdatavalid
);

	// Screen coordinates from the DMA word address
	logic [pixbuf_pkg::IN_X_W-1:0] x;
	logic [pixbuf_pkg::IN_Y_W-1:0] y;

	// Decode of the current request
	logic [pixbuf_pkg::SEL_W-1:0] bit_sel;
	logic out_of_range;

	// Request state held for the RAM read cycle
	logic [pixbuf_pkg::SEL_W-1:0] bit_sel_q;
	logic out_of_range_q;
	logic valid_q;

	// Selected pixel of the returned byte
	logic pixel_set;

	// x is a word index, so it starts above the byte offset bits
	assign x = dma_address[pixbuf_pkg::IN_X_LSB +: pixbuf_pkg::IN_X_W];
	// y follows x directly
	assign y = dma_address[pixbuf_pkg::IN_X_LSB + pixbuf_pkg::IN_X_W +: pixbuf_pkg::IN_Y_W];

	// Rotated layout
	// Column index from x, byte within column from y / 8
	assign ram_addr = {
		y[pixbuf_pkg::SEL_W +: pixbuf_pkg::OUT_Y_W],
		x[pixbuf_pkg::OUT_X_W-1:0]
	};

	// Low y bits pick the pixel inside the byte
	assign bit_sel = y[pixbuf_pkg::SEL_W-1:0];

	// Anything at or past 256 in x or y is off the 256 x 256 screen
	assign out_of_range =
		(|x[pixbuf_pkg::IN_X_W-1:pixbuf_pkg::OUT_X_W]) ||
		(|y[pixbuf_pkg::IN_Y_W-1:pixbuf_pkg::OUT_Y_W+pixbuf_pkg::SEL_W]);

	// Valid tracks the read with the RAM's one-cycle latency
	always_ff @(posedge Clock25Mhz)
	begin
		if (rst)
		begin
			valid_q <= 1'b0;
		end
		else
		begin
			valid_q <= dma_read;
		end
	end

	// Per-request decode, loaded every cycle
	// New read each cycle just replaces the last one
	always_ff @(posedge Clock25Mhz)
	begin
		bit_sel_q <= bit_sel;
		out_of_range_q <= out_of_range;
	end

	// Pick the pixel bit out of the returned byte
	assign pixel_set = ram_rdata[bit_sel_q];

	// Expand one bit into an RGB word
	always_comb
	begin
		dma_readdata = pixbuf_pkg::PIXEL_OFF;
		// Only drive white on a valid, on-screen, set pixel
		if (valid_q && !out_of_range_q && pixel_set)
		begin
			dma_readdata = pixbuf_pkg::PIXEL_ON;
		end
	end

	assign dma_readdatavalid = valid_q;

endmodule

// File: logic/cpu_bus_port.sv
`timescale 1ns/1ps

module cpu_bus_port
(
	input  logic                                Clock25Mhz,
	input  logic                                rst,
	input  logic                                as_l,
	input  logic                                rw,
	input  logic                                uds_l,
	input  logic                                lds_l,
	input  logic [pixbuf_pkg::ADDR_W-1:0]       addr,
	input  logic [pixbuf_pkg::DATA_W-1:0]       wdata,
	input  logic [pixbuf_pkg::BYTE_W-1:0]       ram_rdata,
	output logic [pixbuf_pkg::BUF_ADDR_W-1:0]   ram_addr,
	output logic                                ram_we,
	output logic [pixbuf_pkg::BYTE_W-1:0]       ram_wdata,
	output logic [pixbuf_pkg::DATA_W-1:0]       cpu_rdata,
	output logic                                cpu_rdata_valid
);

	// Window decode
	logic window_hit;
	logic read_hit;

	// Read flag and lane enables, aligned with RAM latency
	logic read_q;
	logic upper_q;
	logic lower_q;

	// Upper address bits must match the tag while AS is asserted
	assign window_hit = ~as_l &&
		(addr[pixbuf_pkg::ADDR_W-1:pixbuf_pkg::BUF_ADDR_W] == pixbuf_pkg::WINDOW_TAG);

	// Read when the CPU drives rw high
	assign read_hit = window_hit & rw;

	// Byte offset inside the window addresses the buffer directly
	assign ram_addr = addr[pixbuf_pkg::BUF_ADDR_W-1:0];

	// Writes ignore the strobes
	// Only the low data byte reaches the buffer
	assign ram_we = window_hit & ~rw;
	assign ram_wdata = wdata[pixbuf_pkg::BYTE_W-1:0];

	// Capture the read and its lanes at the same edge the RAM samples the address
	always_ff @(posedge Clock25Mhz)
	begin
		if (rst)
		begin
			read_q <= 1'b0;
			upper_q <= 1'b0;
			lower_q <= 1'b0;
		end
		else
		begin
			read_q <= read_hit;
			// Lane strobes are active low
			upper_q <= read_hit & ~uds_l;
			lower_q <= read_hit & ~lds_l;
		end
	end

	// One result per sampled read, no back-pressure
	assign cpu_rdata_valid = read_q;

	// Steer the returned byte onto the enabled lanes
	always_comb
	begin
		cpu_rdata = '0;
		// Upper lane is D15..D8
		if (upper_q)
		begin
			cpu_rdata[pixbuf_pkg::DATA_W-1:pixbuf_pkg::BYTE_W] = ram_rdata;
		end
		// Lower lane is D7..D0
		if (lower_q)
		begin
			cpu_rdata[pixbuf_pkg::BYTE_W-1:0] = ram_rdata;
		end
	end

endmodule

// File: pixel_buffer/pixel_buffer_ram.sv
`timescale 1ns/1ps

module pixel_buffer_ram
(
	input  logic                                Clock25Mhz,
	input  logic [pixbuf_pkg::BUF_ADDR_W-1:0]   a_addr,
	input  logic                                a_we,
	input  logic [pixbuf_pkg::BYTE_W-1:0]       a_wdata,
	output logic [pixbuf_pkg::BYTE_W-1:0]       a_rdata,
	input  logic [pixbuf_pkg::BUF_ADDR_W-1:0]   b_addr,
	output logic [pixbuf_pkg::BYTE_W-1:0]       b_rdata
);

	// 8192 bytes, one bit per pixel
	logic [pixbuf_pkg::BYTE_W-1:0] mem [0:(2**pixbuf_pkg::BUF_ADDR_W)-1];

	// Port A, CPU side
	// Read-write with registered read data
	always_ff @(posedge Clock25Mhz)
	begin
		if (a_we)
		begin
			mem[a_addr] <= a_wdata;
		end
		// Read-first, a write returns the previous byte
		a_rdata <= mem[a_addr];
	end

	// Port B, video side
	// Read-only, address applied every cycle
	always_ff @(posedge Clock25Mhz)
	begin
		// Same-cycle write on port A is not yet visible here
		b_rdata <= mem[b_addr];
	end

endmodule

// File: common/pixbuf_pkg.sv
package pixbuf_pkg;

	// 68000 bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 16;

	// Pixel buffer is byte wide, 8 KiB deep
	localparam int BYTE_W = 8;
	localparam int BUF_ADDR_W = 13;

	// Address bits 31..13 that select the buffer window
	// Base address 0x0100_0000
	localparam logic [ADDR_W-BUF_ADDR_W-1:0] WINDOW_TAG = 19'h00800;

	// DMA word address layout
	// x field starts above the byte offset within the RGB word
	localparam int IN_X_LSB = 2;
	localparam int IN_X_W = 10;
	// y field sits right above x
	localparam int IN_Y_W = 9;

	// Rotated screen layout in the buffer
	// 256 columns, 32 bytes per column
	localparam int OUT_X_W = 8;
	localparam int OUT_Y_W = 5;

	// Bit index of a pixel inside its byte
	localparam int SEL_W = 3;

	// Pixel DMA read data
	localparam int RGB_W = 32;

	// White for a set bit
	localparam logic [RGB_W-1:0] PIXEL_ON = 32'h00FF_FFFF;
	// Black for a clear bit or off screen
	localparam logic [RGB_W-1:0] PIXEL_OFF = 32'h0000_0000;

endpackage
